//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_adc_capture
BUILD_DIR ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
BIN     := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/adc_line_driver.sv
`include "adc_capture_macros.svh"

module adc_line_driver (
    input  logic                                     adc_pbck,
    input  logic [`MAX_CHANNELS*`SAMPLE_BITS-1:0]    frame_words,
    input  adc_capture_pkg::adc_format_t             fmt,
    output logic                                     adc_plrck,
    output logic [`NUM_LINES-1:0]                    adc_pdata,
    output int                                       frame_no
);

    import adc_capture_pkg::*;

    logic [`MAX_CHANNELS*`SAMPLE_BITS-1:0] words;
    adc_format_t                           word_fmt;

    // Serial bit k of a half for one word, zero outside the 24-bit window
    function automatic logic line_bit(input sample_t w, input adc_format_t f, input int k);
        int idx;
        case (f)
            FMT_I2S: idx = `SAMPLE_BITS - k;
            FMT_LJ:  idx = `SAMPLE_BITS - 1 - k;
            default: idx = `HALF_BITS - 1 - k;
        endcase
        if (idx < 0 || idx >= `SAMPLE_BITS) begin
            return 1'b0;
        end
        return w[idx[4:0]];
    endfunction

    // Frames run back to back, words and format are latched at each frame start
    initial begin
        adc_plrck = 1'b0;
        adc_pdata = '0;
        frame_no  = 0;
        words     = '0;
        word_fmt  = FMT_I2S;
        forever begin
            for (int h = 0; h < 2; h++) begin
                for (int k = 0; k < `HALF_BITS; k++) begin
                    @(posedge adc_pbck);
                    #2;
                    if (h == 0 && k == 0) begin
                        words    = frame_words;
                        word_fmt = fmt;
                        frame_no = frame_no + 1;
                    end
                    // Low half carries left words, high half right words
                    adc_plrck = (h == 1);
                    for (int i = 0; i < `NUM_LINES; i++) begin
                        adc_pdata[i] = line_bit(
                            words[(2*i+h)*`SAMPLE_BITS +: `SAMPLE_BITS], word_fmt, k);
                    end
                end
            end
        end
    end

endmodule

//--- bench/tb_adc_capture.sv
`include "adc_capture_macros.svh"

module tb_adc_capture;

    import adc_capture_pkg::*;

    localparam int total_frames = 40;
    localparam int cycle_limit  = 64 * total_frames + 256;

    logic adc_pbck, sclk, adc_plrck, cmd_valid, credit_return;
    logic [`NUM_LINES-1:0] adc_pdata;
    cmd_byte_t cmd_byte, hwcon, exp_hwcon;
    logic sample_valid, overflow;
    sample_t sample_data;
    chan_idx_t sample_chan;

    logic [`MAX_CHANNELS*`SAMPLE_BITS-1:0] next_frame, live_frame;
    adc_format_t drv_fmt;
    int drv_frame_no;
    integer seed = 32'hfd4132d4;

    // Reference model state
    logic tb_rec, tb_mode, armed, lossy, starve, live_dirty, acon_wait;
    sample_t exp_data[$];
    int exp_chan[$];
    bit exp_care[$];
    sample_t cand[$];
    sample_t grp[$];
    cmd_byte_t cmd_q[$];
    int credits_tb, owed, gap, cycles, r;

    adc_capture_top adc_capture_top_inst (
        .adc_pbck(adc_pbck), .sclk(sclk), .adc_plrck(adc_plrck), .adc_pdata(adc_pdata),
        .cmd_valid(cmd_valid), .cmd_byte(cmd_byte), .credit_return(credit_return),
        .sample_valid(sample_valid), .sample_data(sample_data), .sample_chan(sample_chan),
        .overflow(overflow), .hwcon(hwcon)
    );

    adc_line_driver line_driver_inst (
        .adc_pbck(adc_pbck), .frame_words(next_frame), .fmt(drv_fmt),
        .adc_plrck(adc_plrck), .adc_pdata(adc_pdata), .frame_no(drv_frame_no)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("Mismatch at time %0t: %s expected %0h actual %0h",
                               $time, name, expected, actual));
        end
    endtask

    function automatic logic [`MAX_CHANNELS*`SAMPLE_BITS-1:0] random_frame();
        logic [`MAX_CHANNELS*`SAMPLE_BITS-1:0] f;
        int rv;
        for (int c = 0; c < `MAX_CHANNELS; c++) begin
            rv = $random(seed);
            f[c*`SAMPLE_BITS +: `SAMPLE_BITS] = rv[23:0];
        end
        return f;
    endfunction

    // Model of the command rules where a pending argument byte wins over the codes
    task automatic apply_cmd(input cmd_byte_t b);
        if (acon_wait) begin
            exp_hwcon = b;
            acon_wait = 1'b0;
        end else begin
            case (b)
                `CMD_START_REC: tb_rec = 1'b1;
                `CMD_STOP_REC:  tb_rec = 1'b0;
                `CMD_MODE_2CH:  tb_mode = 1'b0;
                `CMD_MODE_8CH:  tb_mode = 1'b1;
                `CMD_SET_ACON:  acon_wait = 1'b1;
                `CMD_FMT_I2S, `CMD_FMT_LJ, `CMD_FMT_RJ: begin
                    drv_fmt    = (b == `CMD_FMT_LJ) ? FMT_LJ :
                                 (b == `CMD_FMT_RJ) ? FMT_RJ : FMT_I2S;
                    live_dirty = 1'b1;
                end
                default: ;
            endcase
        end
    endtask

    // Frame just finished is sent only when recording was on at both closes
    task automatic close_frame();
        if (armed && tb_rec) begin
            for (int c = 0; c < (tb_mode ? `MAX_CHANNELS : 2); c++) begin
                if (lossy) begin
                    cand.push_back(live_frame[c*`SAMPLE_BITS +: `SAMPLE_BITS]);
                end else begin
                    exp_data.push_back(live_frame[c*`SAMPLE_BITS +: `SAMPLE_BITS]);
                    exp_chan.push_back(c);
                    exp_care.push_back(!live_dirty);
                end
            end
        end
        armed = tb_rec;
    endtask

    task automatic run_frames(input int count);
        int n;
        repeat (count) begin
            n = drv_frame_no;
            wait (drv_frame_no != n);
            close_frame();
            live_frame = next_frame;
            live_dirty = 1'b0;
            next_frame = random_frame();
            // Commands go out mid frame well clear of frame_valid
            if (cmd_q.size() > 0) begin
                repeat (8) @(posedge adc_pbck);
                while (cmd_q.size() > 0) begin
                    @(posedge adc_pbck);
                    #2;
                    cmd_valid = 1'b1;
                    cmd_byte  = cmd_q.pop_front();
                    apply_cmd(cmd_byte);
                end
                @(posedge adc_pbck);
                #2;
                cmd_valid = 1'b0;
            end
        end
    endtask

    task automatic match_group();
        bit found;
        bit same;
        found = 1'b0;
        for (int f = 0; f < cand.size() / `MAX_CHANNELS; f++) begin
            same = 1'b1;
            for (int c = 0; c < `MAX_CHANNELS; c++) begin
                if (cand[f*`MAX_CHANNELS+c] !== grp[c]) same = 1'b0;
            end
            if (same) found = 1'b1;
        end
        if (!found) fail_run("Received frame matches no frame that was sent");
        grp.delete();
    endtask

    initial begin
        adc_pbck = 1'b0;
        forever #20 adc_pbck = ~adc_pbck;
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge adc_pbck);
            cycles++;
        end
        fail_run("Timeout: the run did not finish within the cycle limit");
    end

    // Consumer returns each credit after a random gap unless starved
    initial begin
        credit_return = 1'b0;
        owed = 0;
        gap  = 0;
        forever begin
            @(negedge adc_pbck);
            if (sample_valid) owed++;
            @(posedge adc_pbck);
            #2;
            credit_return = 1'b0;
            if (!starve && owed > 0) begin
                if (gap == 0) begin
                    credit_return = 1'b1;
                    owed--;
                    r   = $random(seed);
                    gap = r & 3;
                end else begin
                    gap--;
                end
            end
        end
    end

    // Output monitor with credit tracking
    initial begin
        credits_tb = `CREDIT_MAX;
        forever begin
            @(negedge adc_pbck);
            if (sample_valid && credits_tb == 0) begin
                fail_run("sample_valid was high with no outstanding credit");
            end else if (sample_valid && lossy) begin
                credits_tb--;
                grp.push_back(sample_data);
                check_value("sample_chan", 32'(grp.size() - 1), 32'(sample_chan));
                if (grp.size() == `MAX_CHANNELS) match_group();
            end else if (sample_valid && exp_data.size() == 0) begin
                fail_run("sample_valid was high with no sample expected");
            end else if (sample_valid) begin
                credits_tb--;
                check_value("sample_chan", 32'(exp_chan.pop_front()), 32'(sample_chan));
                if (exp_care.pop_front()) begin
                    check_value("sample_data", 32'(exp_data.pop_front()), 32'(sample_data));
                end else begin
                    void'(exp_data.pop_front());
                end
            end
            if (credit_return) credits_tb++;
        end
    end

    initial begin
        sclk = 1'b1;
        cmd_valid = 1'b0;
        cmd_byte = '0;
        {tb_rec, tb_mode, armed, lossy, starve, live_dirty, acon_wait} = '0;
        exp_hwcon = '0;
        drv_fmt = FMT_I2S;
        next_frame = random_frame();
        repeat (4) @(posedge adc_pbck);
        #2;
        sclk = 1'b0;

        // Idle with recording off
        run_frames(3);
        check_value("hwcon", 32'(exp_hwcon), 32'(hwcon));
        check_value("overflow", 0, 32'(overflow));

        // I2S in 2-channel mode where the first frame after start is skipped
        cmd_q.push_back(`CMD_START_REC);
        run_frames(6);

        cmd_q.push_back(`CMD_FMT_LJ);
        run_frames(5);
        cmd_q.push_back(`CMD_FMT_RJ);
        run_frames(5);

        cmd_q.push_back(`CMD_MODE_8CH);
        run_frames(6);
        check_value("overflow", 0, 32'(overflow));

        // During starvation output is only known as whole frames
        run_frames(1);
        while (exp_data.size() != 0) begin
            @(posedge adc_pbck);
        end
        lossy  = 1'b1;
        starve = 1'b1;
        run_frames(4);
        starve = 1'b0;
        run_frames(3);

        r = $random(seed);
        cmd_q.push_back(`CMD_STOP_REC);
        cmd_q.push_back(`CMD_SET_ACON);
        cmd_q.push_back(r[7:0]);
        run_frames(2);
        check_value("hwcon", 32'(exp_hwcon), 32'(hwcon));
        check_value("overflow", 1, 32'(overflow));
        check_value("partial frame words", 0, 32'(grp.size()));
        lossy = 1'b0;
        run_frames(3);

        if (exp_data.size() != 0) begin
            fail_run("Expected samples were never delivered");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

//--- design/adc_capture_pkg.sv
`include "adc_capture_macros.svh"

package adc_capture_pkg;

    // One audio word as received from a data line
    typedef logic [`SAMPLE_BITS-1:0]  sample_t;

    // Command stream byte, also the hwcon register
    typedef logic [`CMD_BITS-1:0]     cmd_byte_t;

    // Channel number within a frame
    typedef logic [`CHAN_BITS-1:0]    chan_idx_t;

    // Flow control credit count
    typedef logic [`CREDIT_BITS-1:0]  credit_t;

    // Bit position within one half of the frame
    typedef logic [`BIT_CNT_BITS-1:0] bit_cnt_t;

    typedef enum logic [1:0] {
        FMT_I2S,
        FMT_LJ,
        FMT_RJ
    } adc_format_t;

    // Command parser state
    typedef enum logic {
        CFG_IDLE,
        CFG_ARG
    } cfg_state_t;

endpackage

//--- design/adc_capture_top.sv
`include "adc_capture_macros.svh"

module adc_capture_top (
    input  logic                       adc_pbck,
    input  logic                       sclk,
    input  logic                       adc_plrck,
    input  logic [`NUM_LINES-1:0]      adc_pdata,
    input  logic                       cmd_valid,
    input  adc_capture_pkg::cmd_byte_t cmd_byte,
    input  logic                       credit_return,
    output logic                       sample_valid,
    output adc_capture_pkg::sample_t   sample_data,
    output adc_capture_pkg::chan_idx_t sample_chan,
    output logic                       overflow,
    output adc_capture_pkg::cmd_byte_t hwcon
);

    import adc_capture_pkg::*;

    logic        rec_enable;
    logic        mode_8ch;
    adc_format_t adc_format;
    logic        frame_valid;
    sample_t     frame_samples [0:`MAX_CHANNELS-1];

    // Command parser steering both datapath blocks
    slot_config slot_config_inst (
        .adc_pbck   (adc_pbck),
        .sclk       (sclk),
        .cmd_valid  (cmd_valid),
        .cmd_byte   (cmd_byte),
        .rec_enable (rec_enable),
        .adc_format (adc_format),
        .mode_8ch   (mode_8ch),
        .hwcon      (hwcon)
    );

    frame_deserializer frame_deserializer_inst (
        .adc_pbck      (adc_pbck),
        .sclk          (sclk),
        .adc_plrck     (adc_plrck),
        .adc_pdata     (adc_pdata),
        .adc_format    (adc_format),
        .frame_valid   (frame_valid),
        .frame_samples (frame_samples)
    );

    channel_sequencer channel_sequencer_inst (
        .adc_pbck      (adc_pbck),
        .sclk          (sclk),
        .frame_valid   (frame_valid),
        .frame_samples (frame_samples),
        .rec_enable    (rec_enable),
        .mode_8ch      (mode_8ch),
        .credit_return (credit_return),
        .sample_valid  (sample_valid),
        .sample_data   (sample_data),
        .sample_chan   (sample_chan),
        .overflow      (overflow)
    );

endmodule

//--- design/channel_sequencer.sv
`include "adc_capture_macros.svh"

module channel_sequencer (
    input  logic                       adc_pbck,
    input  logic                       sclk,
    input  logic                       frame_valid,
    input  adc_capture_pkg::sample_t   frame_samples [0:`MAX_CHANNELS-1],
    input  logic                       rec_enable,
    input  logic                       mode_8ch,
    input  logic                       credit_return,
    output logic                       sample_valid,
    output adc_capture_pkg::sample_t   sample_data,
    output adc_capture_pkg::chan_idx_t sample_chan,
    output logic                       overflow
);

    import adc_capture_pkg::*;

    // Recording state seen at the previous frame
    logic      rec_armed;

    logic      busy;
    logic      held_8ch;
    chan_idx_t next_idx;
    chan_idx_t last_idx;
    sample_t   held [0:`MAX_CHANNELS-1];

    credit_t   credits;
    credit_t   credits_avail;

    logic      emit;
    logic      emit_last;
    logic      held_free;
    logic      frame_wanted;
    logic      take_frame;
    logic      drop_frame;

    assign last_idx = held_8ch ? chan_idx_t'(`MAX_CHANNELS - 1) : chan_idx_t'(1);

    // Sample on the output this cycle has already used its credit
    assign credits_avail = credits - credit_t'(sample_valid);

    assign emit      = busy && (credits_avail != '0);
    assign emit_last = emit && (next_idx == last_idx);

    // Holding register frees up on the cycle the last channel goes out
    assign held_free    = !busy || emit_last;
    assign frame_wanted = frame_valid && rec_armed && rec_enable;
    assign take_frame   = frame_wanted && held_free;
    assign drop_frame   = frame_wanted && !held_free;

    always_ff @(posedge adc_pbck or posedge sclk) begin
        if (sclk) begin
            rec_armed    <= 1'b0;
            busy         <= 1'b0;
            held_8ch     <= 1'b0;
            next_idx     <= '0;
            credits      <= credit_t'(`CREDIT_MAX);
            sample_valid <= 1'b0;
            overflow     <= 1'b0;
        end else begin
            credits      <= credits_avail + credit_t'(credit_return);
            sample_valid <= emit;
            if (frame_valid) begin
                rec_armed <= rec_enable;
            end
            if (emit) begin
                next_idx <= next_idx + chan_idx_t'(1);
            end
            if (emit_last) begin
                busy <= 1'b0;
            end
            // A new frame overrides the end of the previous one
            if (take_frame) begin
                busy     <= 1'b1;
                held_8ch <= mode_8ch;
                next_idx <= '0;
            end
            if (drop_frame) begin
                overflow <= 1'b1; // sticky until reset
            end
        end
    end

    always_ff @(posedge adc_pbck) begin
        if (take_frame) begin
            held <= frame_samples;
        end
        if (emit) begin
            sample_data <= held[next_idx];
            sample_chan <= next_idx;
        end
    end

    // Consumer returns only what it was given
    credit_limit_a: assert property (
        @(posedge adc_pbck) disable iff (sclk)
        credits <= credit_t'(`CREDIT_MAX)
    );

    // Every sample on the stream is covered by a credit
    credit_cover_a: assert property (
        @(posedge adc_pbck) disable iff (sclk)
        sample_valid |-> (credits != '0)
    );

endmodule

//--- design/frame_deserializer.sv
`include "adc_capture_macros.svh"

module frame_deserializer (
    input  logic                         adc_pbck,
    input  logic                         sclk,
    input  logic                         adc_plrck,
    input  logic [`NUM_LINES-1:0]        adc_pdata,
    input  adc_capture_pkg::adc_format_t adc_format,
    output logic                         frame_valid,
    output adc_capture_pkg::sample_t     frame_samples [0:`MAX_CHANNELS-1]
);

    import adc_capture_pkg::*;

    // Input stage, the frame clock is kept one more cycle for edge detection
    logic                  lrck_q;
    logic                  lrck_qq;
    logic [`NUM_LINES-1:0] pdata_q;

    bit_cnt_t              bit_cnt;
    bit_cnt_t              bit_pos;
    logic                  lrck_edge;
    logic                  lrck_fall;
    logic                  shift_en;

    sample_t               left_sr  [0:`NUM_LINES-1];
    sample_t               right_sr [0:`NUM_LINES-1];

    assign lrck_edge = lrck_q ^ lrck_qq;
    assign lrck_fall = lrck_qq & ~lrck_q;

    // Position of the bit now in pdata_q, zero on the first clock of a half
    assign bit_pos = lrck_edge ? '0 : bit_cnt + bit_cnt_t'(1);

    // Bit window per format, 24 bits taken from each 32-bit half
    always_comb begin
        case (adc_format)
            FMT_I2S: begin
                // MSB one clock after the frame clock transition
                shift_en = (bit_pos >= bit_cnt_t'(1)) &&
                           (bit_pos <= bit_cnt_t'(`SAMPLE_BITS));
            end
            FMT_LJ: begin
                shift_en = bit_pos < bit_cnt_t'(`SAMPLE_BITS);
            end
            FMT_RJ: begin
                // LSB lands on the last clock of the half
                shift_en = bit_pos >= bit_cnt_t'(`HALF_BITS - `SAMPLE_BITS);
            end
            default: begin
                shift_en = 1'b0;
            end
        endcase
    end

    always_ff @(posedge adc_pbck or posedge sclk) begin
        if (sclk) begin
            lrck_q      <= 1'b0;
            lrck_qq     <= 1'b0;
            bit_cnt     <= '0;
            frame_valid <= 1'b0;
        end else begin
            lrck_q      <= adc_plrck;
            lrck_qq     <= lrck_q;
            bit_cnt     <= bit_pos;
            frame_valid <= lrck_fall;
        end
    end

    always_ff @(posedge adc_pbck) begin
        pdata_q <= adc_pdata;
    end

    // Low half feeds the left words, high half the right words
    always_ff @(posedge adc_pbck) begin
        for (int i = 0; i < `NUM_LINES; i++) begin
            if (shift_en && !lrck_q) begin
                left_sr[i] <= {left_sr[i][`SAMPLE_BITS-2:0], pdata_q[i]};
            end
            if (shift_en && lrck_q) begin
                right_sr[i] <= {right_sr[i][`SAMPLE_BITS-2:0], pdata_q[i]};
            end
        end
    end

    // Falling frame clock closes the frame, old left words still intact here
    always_ff @(posedge adc_pbck) begin
        if (lrck_fall) begin
            for (int i = 0; i < `NUM_LINES; i++) begin
                frame_samples[2*i]   <= left_sr[i];
                frame_samples[2*i+1] <= right_sr[i];
            end
        end
    end

    // A frame spans 64 bit clocks, so pulses are never closer than a half
    frame_spacing_a: assert property (
        @(posedge adc_pbck) disable iff (sclk)
        frame_valid |=> !frame_valid [*(`HALF_BITS - 1)]
    );

endmodule

//--- design/slot_config.sv
`include "adc_capture_macros.svh"

module slot_config (
    input  logic                         adc_pbck,
    input  logic                         sclk,
    input  logic                         cmd_valid,
    input  adc_capture_pkg::cmd_byte_t   cmd_byte,
    output logic                         rec_enable,
    output adc_capture_pkg::adc_format_t adc_format,
    output logic                         mode_8ch,
    output adc_capture_pkg::cmd_byte_t   hwcon
);

    import adc_capture_pkg::*;

    cfg_state_t state;

    // Every byte with cmd_valid is consumed and nothing stalls the stream
    always_ff @(posedge adc_pbck or posedge sclk) begin
        if (sclk) begin
            state      <= CFG_IDLE;
            rec_enable <= 1'b0;
            adc_format <= FMT_I2S;
            mode_8ch   <= 1'b0;
            hwcon      <= '0;
        end else if (cmd_valid) begin
            case (state)
                CFG_IDLE: begin
                    case (cmd_byte)
                        `CMD_START_REC: begin
                            rec_enable <= 1'b1;
                        end
                        `CMD_STOP_REC: begin
                            rec_enable <= 1'b0;
                        end
                        `CMD_FMT_I2S: begin
                            adc_format <= FMT_I2S;
                        end
                        `CMD_FMT_LJ: begin
                            adc_format <= FMT_LJ;
                        end
                        `CMD_FMT_RJ: begin
                            adc_format <= FMT_RJ;
                        end
                        `CMD_MODE_2CH: begin
                            mode_8ch <= 1'b0;
                        end
                        `CMD_MODE_8CH: begin
                            mode_8ch <= 1'b1;
                        end
                        // Next byte is the hwcon value
                        `CMD_SET_ACON: begin
                            state <= CFG_ARG;
                        end
                        // Unknown codes fall through silently
                        default: begin
                            state <= CFG_IDLE;
                        end
                    endcase
                end
                CFG_ARG: begin
                    hwcon <= cmd_byte;
                    state <= CFG_IDLE;
                end
                default: begin
                    state <= CFG_IDLE;
                end
            endcase
        end
    end

    // Format register only ever holds one of the three decoded formats
    fmt_legal_a: assert property (
        @(posedge adc_pbck) disable iff (sclk)
        adc_format inside {FMT_I2S, FMT_LJ, FMT_RJ}
    );

endmodule

//--- include/adc_capture_macros.svh
`ifndef ADC_CAPTURE_MACROS_SVH
`define ADC_CAPTURE_MACROS_SVH

// Audio word and serial port geometry
`define SAMPLE_BITS     24
`define NUM_LINES       4
`define MAX_CHANNELS    8
`define HALF_BITS       32

// Vector widths behind the package typedefs
`define CMD_BITS        8
`define CHAN_BITS       3
`define CREDIT_BITS     4
`define BIT_CNT_BITS    5

// Credits held by the sequencer after reset, also the ceiling
`define CREDIT_MAX      8

// Recording control
`define CMD_START_REC   8'h50
`define CMD_STOP_REC    8'h51

// ADC serial format selection
`define CMD_FMT_I2S     8'h60
`define CMD_FMT_LJ      8'h61
`define CMD_FMT_RJ      8'h62

// Channel count per frame
`define CMD_MODE_2CH    8'h70
`define CMD_MODE_8CH    8'h71

// Followed by one argument byte for hwcon
`define CMD_SET_ACON    8'h40

`endif

//--- vlog.f
+incdir+include
design/adc_capture_pkg.sv
design/slot_config.sv
design/frame_deserializer.sv
design/channel_sequencer.sv
design/adc_capture_top.sv
bench/adc_line_driver.sv
bench/tb_adc_capture.sv
